// ==== fpga_reg_bus.f ====
design/fpga_bus_pkg.sv
design/board_regs.sv
design/hub_mem.sv
design/phy_request.sv
design/read_bus_mux.sv
design/fpga_reg_bus.sv
dv/fpga_reg_bus_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the register bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f fpga_reg_bus.f \
    --top-module fpga_reg_bus_tb \
    -o fpga_reg_bus_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/fpga_reg_bus_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "PASS: all tests"; then
    echo "run passed"
    exit 0
else
    echo "run failed"
    exit 1
fi

// ==== dv/fpga_reg_bus_tb.sv ====
//--------------------------------------
// clock, reset, lcg, bus helper tasks and timeout
// directed tests for regs, hub memory, read mux, phy request, watchdog
//--------------------------------------
`timescale 1ns/10ps
`default_nettype none

module fpga_reg_bus_tb;

    localparam int unsigned NUM_HUB_QUADS = 16;
    localparam int unsigned WDOG_TICK     = 4;     // short watchdog unit for simulation
    localparam int unsigned WDOG_PERIOD   = 5;
    localparam int unsigned MAX_CYCLES    = 2000;  // tests take about 250 cycles

    logic                sysclk;
    logic                arst_n;
    logic [3:0]          board_id;
    fpga_bus_pkg::addr_t reg_raddr;
    fpga_bus_pkg::addr_t reg_waddr;
    fpga_bus_pkg::data_t reg_wdata;
    logic                reg_wen;
    fpga_bus_pkg::data_t reg_rdata_ext;
    logic                reg_rwait_ext;
    logic                wdog_clear;
    fpga_bus_pkg::data_t reg_rdata;
    logic                reg_rwait;
    logic                lreq;
    logic                wdog_timeout;

    int unsigned err_cnt   = 0;
    int unsigned chk_cnt   = 0;
    int unsigned cycle_cnt = 0;
    logic [31:0] lcg_state;

    fpga_reg_bus #(
        .NUM_HUB_QUADS (NUM_HUB_QUADS),
        .WDOG_TICK     (WDOG_TICK)
    ) u_fpga_reg_bus (
        .sysclk        (sysclk),
        .arst_n        (arst_n),
        .board_id      (board_id),
        .reg_raddr     (reg_raddr),
        .reg_waddr     (reg_waddr),
        .reg_wdata     (reg_wdata),
        .reg_wen       (reg_wen),
        .reg_rdata_ext (reg_rdata_ext),
        .reg_rwait_ext (reg_rwait_ext),
        .wdog_clear    (wdog_clear),
        .reg_rdata     (reg_rdata),
        .reg_rwait     (reg_rwait),
        .lreq          (lreq),
        .wdog_timeout  (wdog_timeout)
    );

    always #50 sysclk = ~sysclk;   // 100 ns period

    // cycle limit ends a hung run
    always @(posedge sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    //--------------------------------------
    // helpers
    //--------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // region main channel 0
    function automatic fpga_bus_pkg::addr_t main_addr(input logic [3:0] ofs);
        return {fpga_bus_pkg::ADDR_MAIN, 8'h00, ofs};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        chk_cnt++;
        assert (got === exp) else begin
            $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    // inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge sysclk);
        #1;
    endtask

    task automatic bus_write(input fpga_bus_pkg::addr_t addr, input logic [31:0] data);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        next_cycle();           // write sampled here
        reg_wen   = 1'b0;
    endtask

    // no-wait read checks data in the same cycle
    task automatic read_comb(input fpga_bus_pkg::addr_t addr, input logic [31:0] exp,
                             input logic exp_wait);
        reg_raddr = addr;
        #10;
        check_val("reg_rwait", {31'd0, reg_rwait}, {31'd0, exp_wait});
        check_val("reg_rdata", reg_rdata, exp);
    endtask

    // waited read with data valid after the next edge
    task automatic read_hub(input fpga_bus_pkg::addr_t addr, input logic [31:0] exp);
        reg_raddr = addr;
        #10;
        check_val("reg_rwait", {31'd0, reg_rwait}, 32'd1);
        next_cycle();
        check_val("reg_rdata", reg_rdata, exp);
    endtask

    //--------------------------------------
    // directed tests
    //--------------------------------------
    task automatic test_reset_version();
        check_val("lreq", {31'd0, lreq}, 32'd0);
        check_val("wdog_timeout", {31'd0, wdog_timeout}, 32'd0);
        read_comb(main_addr(fpga_bus_pkg::REG_VERSION), fpga_bus_pkg::FW_VERSION, 1'b0);
        read_comb(main_addr(fpga_bus_pkg::REG_STATUS), {4'd0, board_id, 24'd0}, 1'b0);
        read_comb(main_addr(4'd2), 32'd0, 1'b0);   // unused offset reads 0
    endtask

    task automatic test_hub_mem();
        logic [31:0] seed_save;
        seed_save = lcg_state;
        for (int i = 0; i < NUM_HUB_QUADS; i++)
            bus_write({fpga_bus_pkg::ADDR_HUB, 12'(i)}, lcg_next());
        lcg_state = seed_save;  // replay the same data for the compare
        for (int i = 0; i < NUM_HUB_QUADS; i++)
            read_hub({fpga_bus_pkg::ADDR_HUB, 12'(i)}, lcg_next());
    endtask

    task automatic test_region_decode();
        logic [31:0] ext;
        ext = lcg_next();
        reg_rdata_ext = ext;
        read_comb(16'h5000, ext, 1'b0);    // unused region
        read_comb(16'h0017, ext, 1'b0);    // main channel 1
        read_comb(main_addr(fpga_bus_pkg::REG_VERSION), fpga_bus_pkg::FW_VERSION | ext, 1'b0);
        reg_rwait_ext = 1'b1;
        read_comb(main_addr(fpga_bus_pkg::REG_VERSION), fpga_bus_pkg::FW_VERSION | ext, 1'b1);
        reg_rwait_ext = 1'b0;
        reg_rdata_ext = '0;
        next_cycle();
    endtask

    // one PHYCTRL write then lreq followed bit by bit
    task automatic send_phy_frame(input logic [31:0] wdata, input logic retrig,
                                  output logic [31:0] last_wr);
        logic [15:0] frame;
        int          nbits;
        if (wdata[12]) begin
            frame = {1'b1, fpga_bus_pkg::LREQ_REG_WR, wdata[11:8], wdata[7:0]};
            nbits = fpga_bus_pkg::LREQ_WR_BITS;
        end else begin
            frame = {1'b1, fpga_bus_pkg::LREQ_REG_RD, wdata[11:8], 8'h00};
            nbits = fpga_bus_pkg::LREQ_RD_BITS;
        end
        last_wr   = wdata;
        reg_waddr = main_addr(fpga_bus_pkg::REG_PHYCTRL);
        reg_wdata = wdata;
        reg_wen   = 1'b1;
        next_cycle();
        for (int i = 0; i < nbits; i++) begin
            check_val("lreq", {31'd0, lreq}, {31'd0, frame[15]});
            frame = frame << 1;
            if (retrig && i == 2) begin
                reg_wdata = ~wdata;     // every bit differs and must not reach lreq
                reg_wen   = 1'b1;
                last_wr   = ~wdata;
            end else begin
                reg_wen   = 1'b0;
            end
            next_cycle();
        end
        check_val("lreq", {31'd0, lreq}, 32'd0);  // stop bit
        repeat (4) begin
            next_cycle();
            check_val("lreq", {31'd0, lreq}, 32'd0);
        end
    endtask

    task automatic test_phy_request();
        logic [31:0] d;
        logic [31:0] last;
        d     = lcg_next();
        d[12] = 1'b0;           // register read request
        send_phy_frame(d, 1'b0, last);
        read_comb(main_addr(fpga_bus_pkg::REG_PHYCTRL), {19'd0, last[12:0]}, 1'b0);
        d     = lcg_next();
        d[12] = 1'b1;           // register write request
        send_phy_frame(d, 1'b1, last);
        read_comb(main_addr(fpga_bus_pkg::REG_PHYCTRL), {19'd0, last[12:0]}, 1'b0);
        next_cycle();
    endtask

    // low one cycle before the limit and high on it
    task automatic wait_expiry(input int unsigned limit);
        repeat (limit - 1) next_cycle();
        check_val("wdog_timeout", {31'd0, wdog_timeout}, 32'd0);
        next_cycle();
        check_val("wdog_timeout", {31'd0, wdog_timeout}, 32'd1);
    endtask

    task automatic test_watchdog();
        int unsigned limit;
        limit = WDOG_TICK * WDOG_PERIOD;
        bus_write(main_addr(fpga_bus_pkg::REG_WDOG), WDOG_PERIOD);
        read_comb(main_addr(fpga_bus_pkg::REG_WDOG), WDOG_PERIOD, 1'b0);
        wait_expiry(limit);
        // timeout flag shows in status bit 0
        read_comb(main_addr(fpga_bus_pkg::REG_STATUS), {4'd0, board_id, 23'd0, 1'b1}, 1'b0);
        bus_write(main_addr(fpga_bus_pkg::REG_STATUS), 32'd1);  // clear via status bit 0
        check_val("wdog_timeout", {31'd0, wdog_timeout}, 32'd0);
        wait_expiry(limit);
        wdog_clear = 1'b1;
        next_cycle();
        wdog_clear = 1'b0;
        check_val("wdog_timeout", {31'd0, wdog_timeout}, 32'd0);
        // no write since the last expiry so no new timeout
        repeat (limit) begin
            next_cycle();
            check_val("wdog_timeout", {31'd0, wdog_timeout}, 32'd0);
        end
        bus_write(main_addr(fpga_bus_pkg::REG_WDOG), 32'd0);   // watchdog off
        repeat (100) begin
            next_cycle();
            check_val("wdog_timeout", {31'd0, wdog_timeout}, 32'd0);
        end
    endtask

    //--------------------------------------
    // main sequence
    //--------------------------------------
    initial begin
        sysclk        = 1'b0;
        arst_n        = 1'b0;
        board_id      = 4'ha;
        reg_raddr     = '0;
        reg_waddr     = '0;
        reg_wdata     = '0;
        reg_wen       = 1'b0;
        reg_rdata_ext = '0;
        reg_rwait_ext = 1'b0;
        wdog_clear    = 1'b0;
        lcg_state     = 32'hdd29_3f57;
        repeat (5) @(posedge sysclk);
        #1;
        arst_n = 1'b1;
        next_cycle();

        test_reset_version();
        test_hub_mem();
        test_region_decode();
        test_phy_request();
        test_watchdog();

        $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/fpga_reg_bus.sv ====
//--------------------------------------
// register bus core: board regs, hub memory, read mux, phy request
//--------------------------------------
`timescale 1ns/10ps
`default_nettype none

module fpga_reg_bus #(
    parameter int unsigned NUM_HUB_QUADS = 16,  // hub depth, power of two
    parameter int unsigned WDOG_TICK     = 1024 // sysclk cycles per wdog unit
) (
    input  wire logic                sysclk,
    input  wire logic                arst_n,
    input  wire logic [3:0]          board_id,       // rotary switch
    // host read / write bus
    input  wire fpga_bus_pkg::addr_t reg_raddr,
    input  wire fpga_bus_pkg::addr_t reg_waddr,
    input  wire fpga_bus_pkg::data_t reg_wdata,
    input  wire logic                reg_wen,        // one-cycle write strobe
    input  wire fpga_bus_pkg::data_t reg_rdata_ext,  // external read data, ORed in
    input  wire logic                reg_rwait_ext,
    input  wire logic                wdog_clear,
    output wire fpga_bus_pkg::data_t reg_rdata,
    output wire logic                reg_rwait,
    output wire logic                lreq,           // serial phy request
    output wire logic                wdog_timeout
);

    //--------------------------------------
    // internal read data
    //--------------------------------------
    fpga_bus_pkg::data_t board_rdata;   // channel 0 registers, no wait
    fpga_bus_pkg::data_t hub_rdata;     // hub memory, one cycle

    board_regs #(
        .WDOG_TICK (WDOG_TICK)
    ) u_board_regs (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .board_id     (board_id),
        .reg_raddr    (reg_raddr),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .reg_wen      (reg_wen),
        .wdog_clear   (wdog_clear),
        .board_rdata  (board_rdata),
        .wdog_timeout (wdog_timeout)
    );

    hub_mem #(
        .NUM_HUB_QUADS (NUM_HUB_QUADS)
    ) u_hub_mem (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .reg_raddr (reg_raddr),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen),
        .hub_rdata (hub_rdata)
    );

    read_bus_mux u_read_bus_mux (
        .reg_raddr     (reg_raddr),
        .board_rdata   (board_rdata),
        .hub_rdata     (hub_rdata),
        .reg_rdata_ext (reg_rdata_ext),
        .reg_rwait_ext (reg_rwait_ext),
        .reg_rdata     (reg_rdata),
        .reg_rwait     (reg_rwait)
    );

    // snoops the write bus for PHYCTRL writes
    phy_request u_phy_request (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen),
        .lreq      (lreq)
    );

endmodule

`default_nettype wire

// ==== design/read_bus_mux.sv ====
//--------------------------------------
// read data mux: region decode, board / hub / external merge
//--------------------------------------
`timescale 1ns/10ps
`default_nettype none

module read_bus_mux (
    input  wire fpga_bus_pkg::addr_t reg_raddr,
    input  wire fpga_bus_pkg::data_t board_rdata,
    input  wire fpga_bus_pkg::data_t hub_rdata,
    input  wire fpga_bus_pkg::data_t reg_rdata_ext,
    input  wire logic                reg_rwait_ext,
    output fpga_bus_pkg::data_t      reg_rdata,
    output logic                     reg_rwait
);

    fpga_bus_pkg::region_t region;
    logic [3:0]            chan;
    fpga_bus_pkg::data_t   sel_rdata;
    logic                  sel_rwait;

    assign region = reg_raddr[15:12];
    assign chan   = reg_raddr[7:4];

    // rwait 0 -> data in the same cycle, 1 -> one edge after the address
    always_comb begin
        if (region == fpga_bus_pkg::ADDR_HUB) begin
            sel_rdata = hub_rdata;          // registered memory read
            sel_rwait = 1'b1;
        end else if (region == fpga_bus_pkg::ADDR_MAIN && chan == 4'd0) begin
            sel_rdata = board_rdata;        // combinational registers
            sel_rwait = 1'b0;
        end else begin
            sel_rdata = '0;                 // external port only
            sel_rwait = 1'b0;
        end
    end

    // external read port is always merged in
    assign reg_rdata = sel_rdata | reg_rdata_ext;
    assign reg_rwait = sel_rwait | reg_rwait_ext;

endmodule

`default_nettype wire

// ==== design/phy_request.sv ====
//--------------------------------------
// phy request generator: PHYCTRL write to serial frame on lreq
//--------------------------------------
`timescale 1ns/10ps
`default_nettype none

module phy_request (
    input  wire logic                sysclk,
    input  wire logic                arst_n,
    input  wire fpga_bus_pkg::addr_t reg_waddr,
    input  wire fpga_bus_pkg::data_t reg_wdata,
    input  wire logic                reg_wen,
    output logic                     lreq
);

    localparam int unsigned CNT_W = $clog2(fpga_bus_pkg::LREQ_WR_BITS);
    localparam logic [CNT_W-1:0] RD_LAST = CNT_W'(fpga_bus_pkg::LREQ_RD_BITS - 1);
    localparam logic [CNT_W-1:0] WR_LAST = CNT_W'(fpga_bus_pkg::LREQ_WR_BITS - 1);

    typedef enum logic {
        ST_IDLE,
        ST_SHIFT
    } state_t;

    state_t                   state;
    logic [CNT_W-1:0]         bit_cnt;    // bits left after the current one
    logic [15:0]              shift_reg;  // frame, msb on the line
    logic                     trig;
    logic                     is_wr;
    fpga_bus_pkg::lreq_type_t rtype;

    // PHYCTRL is main region, channel 0
    assign trig  = reg_wen && (reg_waddr == {fpga_bus_pkg::ADDR_MAIN, 8'h00,
                                             fpga_bus_pkg::REG_PHYCTRL});
    assign is_wr = reg_wdata[12];
    assign rtype = is_wr ? fpga_bus_pkg::LREQ_REG_WR : fpga_bus_pkg::LREQ_REG_RD;

    //--------------------------------------
    // control FSM
    //--------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (trig) begin
                        state   <= ST_SHIFT;
                        bit_cnt <= is_wr ? WR_LAST : RD_LAST;
                    end
                end
                ST_SHIFT: begin
                    // triggers are dropped while a frame is out
                    if (bit_cnt == '0)
                        state <= ST_IDLE;
                    else
                        bit_cnt <= bit_cnt - 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // frame: start, type, phy addr, data (write only)
    // the stop bit is the low level that follows on return to idle
    always_ff @(posedge sysclk) begin
        if (state == ST_IDLE && trig)
            shift_reg <= {1'b1, rtype, reg_wdata[11:8], is_wr ? reg_wdata[7:0] : 8'h00};
        else if (state == ST_SHIFT)
            shift_reg <= {shift_reg[14:0], 1'b0};
    end

    assign lreq = (state == ST_SHIFT) && shift_reg[15];    // low when idle

endmodule

`default_nettype wire

// ==== design/hub_mem.sv ====
//--------------------------------------
// hub quadlet memory, written from the write bus
//--------------------------------------
`timescale 1ns/10ps
`default_nettype none

module hub_mem #(
    parameter int unsigned NUM_HUB_QUADS = 16  // power of two
) (
    input  wire logic                sysclk,
    input  wire logic                arst_n,
    input  wire fpga_bus_pkg::addr_t reg_raddr,
    input  wire fpga_bus_pkg::addr_t reg_waddr,
    input  wire fpga_bus_pkg::data_t reg_wdata,
    input  wire logic                reg_wen,
    output fpga_bus_pkg::data_t      hub_rdata
);

    localparam int unsigned AW = $clog2(NUM_HUB_QUADS);

    fpga_bus_pkg::data_t mem [NUM_HUB_QUADS];

    logic          hub_wr;
    logic [AW-1:0] waddr;   // quadlet index from low address bits
    logic [AW-1:0] raddr;

    assign hub_wr = reg_wen && (reg_waddr[15:12] == fpga_bus_pkg::ADDR_HUB);
    assign waddr  = reg_waddr[AW-1:0];
    assign raddr  = reg_raddr[AW-1:0];

    //--------------------------------------
    // storage
    //--------------------------------------
    always_ff @(posedge sysclk) begin
        if (hub_wr)
            mem[waddr] <= reg_wdata;
    end

    // read port, registered every cycle
    // region is not checked, read_bus_mux picks this word only for ADDR_HUB
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n)
            hub_rdata <= '0;
        else
            hub_rdata <= mem[raddr];    // valid one edge after reg_raddr
    end

endmodule

`default_nettype wire

// ==== design/board_regs.sv ====
//--------------------------------------
// status, version, phy control and watchdog period registers
// watchdog prescaler, period counter and sticky timeout flag
//--------------------------------------
`timescale 1ns/10ps
`default_nettype none

module board_regs #(
    parameter int unsigned WDOG_TICK = 1024    // sysclk cycles per period unit
) (
    input  wire logic                sysclk,
    input  wire logic                arst_n,
    input  wire logic [3:0]          board_id,
    input  wire fpga_bus_pkg::addr_t reg_raddr,
    input  wire fpga_bus_pkg::addr_t reg_waddr,
    input  wire fpga_bus_pkg::data_t reg_wdata,
    input  wire logic                reg_wen,
    input  wire logic                wdog_clear,
    output fpga_bus_pkg::data_t      board_rdata,
    output logic                     wdog_timeout
);

    localparam int unsigned TICK_W = (WDOG_TICK > 1) ? $clog2(WDOG_TICK) : 1;
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(WDOG_TICK - 1);

    logic              main_wr;     // write to main region channel 0
    logic              status_clr;  // status write with bit 0 set
    logic [12:0]       phy_reg;
    logic [15:0]       wdog_period; // 0 -> watchdog off
    logic [TICK_W-1:0] tick_cnt;
    logic [15:0]       unit_cnt;    // completed period units
    logic              wdog_reload;
    logic              wdog_run;
    logic              tick_last;
    logic              wdog_expire;

    assign main_wr = reg_wen && (reg_waddr[15:12] == fpga_bus_pkg::ADDR_MAIN)
                     && (reg_waddr[7:4] == 4'd0);
    assign status_clr = main_wr && (reg_waddr[3:0] == fpga_bus_pkg::REG_STATUS)
                        && reg_wdata[0];

    //--------------------------------------
    // writable registers
    //--------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            phy_reg     <= '0;
            wdog_period <= '0;
        end else if (main_wr) begin
            case (reg_waddr[3:0])
                fpga_bus_pkg::REG_PHYCTRL: phy_reg     <= reg_wdata[12:0];
                fpga_bus_pkg::REG_WDOG:    wdog_period <= reg_wdata[15:0];
                default: ;                 // status bit 0 handled below
            endcase
        end
    end

    //--------------------------------------
    // watchdog
    //--------------------------------------
    // any bus write restarts the count
    assign wdog_reload = reg_wen;
    assign wdog_run    = (wdog_period != 16'd0) && (unit_cnt != wdog_period);
    assign tick_last   = (tick_cnt == TICK_LAST);
    assign wdog_expire = wdog_run && tick_last && ((unit_cnt + 16'd1) == wdog_period);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            tick_cnt <= '0;
            unit_cnt <= '0;
        end else if (wdog_reload) begin
            tick_cnt <= '0;
            unit_cnt <= '0;
        end else if (wdog_run) begin
            if (tick_last) begin
                tick_cnt <= '0;
                unit_cnt <= unit_cnt + 16'd1;   // stops once it reaches the period
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    // sticky until cleared by pin or status write
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n)
            wdog_timeout <= 1'b0;
        else if (wdog_clear || status_clr)
            wdog_timeout <= 1'b0;
        else if (wdog_expire)
            wdog_timeout <= 1'b1;
    end

    // read side decodes the offset only
    always_comb begin
        case (reg_raddr[3:0])
            fpga_bus_pkg::REG_STATUS:  board_rdata = {4'd0, board_id, 23'd0, wdog_timeout};
            fpga_bus_pkg::REG_PHYCTRL: board_rdata = {19'd0, phy_reg};
            fpga_bus_pkg::REG_WDOG:    board_rdata = {16'd0, wdog_period};
            fpga_bus_pkg::REG_VERSION: board_rdata = fpga_bus_pkg::FW_VERSION;
            default:                   board_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/fpga_bus_pkg.sv ====
//--------------------------------------
// register bus types, address regions, board register offsets,
// firmware version and phy request encodings
//--------------------------------------
`default_nettype none

package fpga_bus_pkg;

    //--------------------------------------
    // bus vectors
    //--------------------------------------
    typedef logic [15:0] addr_t;    // region 15..12, channel 7..4, offset 3..0
    typedef logic [31:0] data_t;    // one quadlet
    typedef logic [3:0]  region_t;  // addr bits 15..12

    // address regions
    localparam region_t ADDR_MAIN = 4'd0;   // board registers
    localparam region_t ADDR_HUB  = 4'd2;   // hub quadlet memory

    // board register offsets, channel 0 of ADDR_MAIN
    localparam logic [3:0] REG_STATUS  = 4'd0;  // board id, wdog timeout
    localparam logic [3:0] REG_PHYCTRL = 4'd1;  // phy register access
    localparam logic [3:0] REG_WDOG    = 4'd3;  // watchdog period
    localparam logic [3:0] REG_VERSION = 4'd7;  // firmware version

    localparam data_t FW_VERSION = 32'h4642_0001;

    //--------------------------------------
    // phy link requests
    //--------------------------------------
    typedef enum logic [2:0] {
        LREQ_REG_RD = 3'd1,     // phy register read
        LREQ_REG_WR = 3'd5      // phy register write
    } lreq_type_t;

    // frame lengths on lreq, start bit through last payload bit
    localparam int unsigned LREQ_RD_BITS = 8;   // start, type, addr
    localparam int unsigned LREQ_WR_BITS = 16;  // start, type, addr, data

endpackage

`default_nettype wire
